//--- control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  cpu_types_pkg::instr_u instr,
	output cpu_types_pkg::aluop_t alu_op,
	output logic                  alu_src,
	output logic                  reg_dst,
	output logic                  reg_wen,
	output logic                  jump,
	output cpu_types_pkg::br_t    br,
	output logic                  zero_ext,
	output logic                  illegal
);

	always_comb begin
		alu_op   = cpu_types_pkg::ALU_SLL;
		alu_src  = 1'b0;
		reg_dst  = 1'b0;
		reg_wen  = 1'b0;
		jump     = 1'b0;
		br       = cpu_types_pkg::BR_NONE;
		zero_ext = 1'b0;
		illegal  = 1'b0;
		case (instr.r_view.opcode)
			cpu_types_pkg::RTYPE: begin
				reg_dst = 1'b1;
				reg_wen = 1'b1;
				case (instr.r_view.funct)
					cpu_types_pkg::SLLV: alu_op = cpu_types_pkg::ALU_SLL;
					cpu_types_pkg::SRLV: alu_op = cpu_types_pkg::ALU_SRL;
					cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
					cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
					cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
					cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
					cpu_types_pkg::XOR:  alu_op = cpu_types_pkg::ALU_XOR;
					cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
					default: begin
						reg_wen = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			cpu_types_pkg::ADDIU: begin
				alu_op  = cpu_types_pkg::ALU_ADD;
				alu_src = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_types_pkg::ANDI: begin
				alu_op   = cpu_types_pkg::ALU_AND;
				alu_src  = 1'b1;
				reg_wen  = 1'b1;
				zero_ext = 1'b1;
			end
			cpu_types_pkg::ORI: begin
				alu_op   = cpu_types_pkg::ALU_OR;
				alu_src  = 1'b1;
				reg_wen  = 1'b1;
				zero_ext = 1'b1;
			end
			cpu_types_pkg::LUI: begin
				alu_op  = cpu_types_pkg::ALU_LUI;
				alu_src = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_types_pkg::BEQ: br = cpu_types_pkg::BR_EQ;
			cpu_types_pkg::BNE: br = cpu_types_pkg::BR_NE;
			cpu_types_pkg::J:   jump = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

endmodule

//--- cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input  logic                    CLK,
	input  logic                    nRST,
	input  int                      num_retire,
	input  logic                    instr_valid,
	input  logic                    instr_ready,
	input  logic                    retire_valid,
	input  cpu_types_pkg::word_t    retire_pc,
	input  logic                    retire_wen,
	input  cpu_types_pkg::regbits_t retire_reg,
	input  cpu_types_pkg::word_t    retire_data,
	input  logic                    retire_ready,
	input  logic                    redirect,
	input  cpu_types_pkg::word_t    redirect_pc,
	output logic                    done,
	output int                      checks,
	output int                      errors
);

	cpu_types_pkg::word_t mem [256];
	cpu_types_pkg::word_t regs [32];
	cpu_types_pkg::word_t mpc; // architectural pc of the next retirement.
	int test_checks [5];
	int test_errors [5];
	int retired;
	int cycle;
	int accept_cycle;
	logic first_seen;
	logic was_stalled;
	logic [103:0] held; // retire and redirect outputs at the last edge.

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int t = 0; t < 5; t++) begin
			test_checks[t] = 0;
			test_errors[t] = 0;
		end
		mpc = '0;
		retired = 0;
		cycle = 0;
		accept_cycle = -1;
		first_seen = 1'b0;
		was_stalled = 1'b0;
		held = '0;
		done = 1'b0;
		checks = 0;
		errors = 0;
	end

	task automatic load_word(input int idx, input cpu_types_pkg::word_t w);
		mem[idx] = w;
	endtask

	function automatic string test_name(input int t);
		case (t)
			0: return "retire results";
			1: return "branch redirect";
			2: return "back-pressure hold";
			3: return "reset and latency";
			default: return "register 0";
		endcase
	endfunction

	task automatic score(input int t, input logic ok, input string msg);
		test_checks[t]++;
		checks++;
		if (ok !== 1'b1) begin
			test_errors[t]++;
			errors++;
			$display("[FAIL] %0t ns: %s", $time, msg);
		end
	endtask

	////////////////////////////////////////
	// ISA model that steps one instruction per call

	task automatic run_model(output logic wen, output cpu_types_pkg::regbits_t dst,
		output cpu_types_pkg::word_t data, output logic taken,
		output cpu_types_pkg::word_t target);
		cpu_types_pkg::instr_u w;
		cpu_types_pkg::word_t a;
		cpu_types_pkg::word_t b;
		cpu_types_pkg::word_t sext;
		cpu_types_pkg::word_t zext;
		w = mem[mpc[9:2]];
		a = regs[w.r_view.rs];
		b = regs[w.r_view.rt];
		sext = {{16{w.i_view.imm16[15]}}, w.i_view.imm16};
		zext = {16'h0000, w.i_view.imm16};
		wen = 1'b1;
		dst = w.i_view.rt;
		data = '0;
		taken = 1'b0;
		target = mpc + 32'd4 + (sext << 2);
		case (w.r_view.opcode)
			cpu_types_pkg::RTYPE: begin
				dst = w.r_view.rd;
				case (w.r_view.funct)
					cpu_types_pkg::SLLV: data = b << a[4:0];
					cpu_types_pkg::SRLV: data = b >> a[4:0];
					cpu_types_pkg::ADDU: data = a + b;
					cpu_types_pkg::SUBU: data = a - b;
					cpu_types_pkg::AND:  data = a & b;
					cpu_types_pkg::OR:   data = a | b;
					cpu_types_pkg::XOR:  data = a ^ b;
					cpu_types_pkg::SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wen = 1'b0;
				endcase
			end
			cpu_types_pkg::ADDIU: data = a + sext;
			cpu_types_pkg::ANDI:  data = a & zext;
			cpu_types_pkg::ORI:   data = a | zext;
			cpu_types_pkg::LUI:   data = {w.i_view.imm16, 16'h0000};
			cpu_types_pkg::BEQ: begin
				wen = 1'b0;
				taken = (a == b);
			end
			cpu_types_pkg::BNE: begin
				wen = 1'b0;
				taken = (a != b);
			end
			cpu_types_pkg::J: begin
				wen = 1'b0;
				taken = 1'b1;
				target = {mpc[31:28], w.j_view.addr26, 2'b00};
			end
			default: wen = 1'b0;
		endcase
		if (wen && dst != '0) begin
			regs[dst] = data; // register 0 keeps reading zero.
		end
		mpc = taken ? target : mpc + 32'd4;
	endtask

	always @(posedge CLK) begin : watch
		cpu_types_pkg::instr_u w;
		cpu_types_pkg::word_t exp_pc;
		cpu_types_pkg::word_t exp_data;
		cpu_types_pkg::word_t exp_target;
		cpu_types_pkg::regbits_t exp_reg;
		logic exp_wen;
		logic exp_taken;
		logic r0_case;
		if (nRST) begin
			cycle++;
			if (cycle <= 2) begin
				score(3, instr_ready == (cycle == 2), $sformatf(
					"instr_ready %b in cycle %0d after reset release, expected high from cycle 2",
					instr_ready, cycle));
			end
			if (accept_cycle < 0) begin
				score(3, !retire_valid && !redirect, "retire port active before any acceptance");
				if (instr_valid && instr_ready) begin
					accept_cycle = cycle;
				end
			end else if (!first_seen && retire_valid) begin
				first_seen = 1'b1;
				score(3, cycle - accept_cycle == 3, $sformatf(
					"first retirement %0d cycles after acceptance, expected 3",
					cycle - accept_cycle));
			end
			if (was_stalled) begin
				score(2, held === {retire_valid, retire_pc, retire_wen, retire_reg,
					retire_data, redirect, redirect_pc},
					"retire outputs changed while retire_ready was low");
			end
			was_stalled = retire_valid && !retire_ready;
			held = {retire_valid, retire_pc, retire_wen, retire_reg, retire_data,
				redirect, redirect_pc};
			if (retire_valid && retire_ready && retired < num_retire) begin
				w = mem[mpc[9:2]];
				exp_pc = mpc;
				run_model(exp_wen, exp_reg, exp_data, exp_taken, exp_target);
				score(0, retire_pc == exp_pc && retire_wen == exp_wen &&
					(!exp_wen || (retire_reg == exp_reg && retire_data == exp_data)),
					$sformatf("pc %h wen %b reg %0d data %h, expected pc %h wen %b reg %0d data %h",
					retire_pc, retire_wen, retire_reg, retire_data,
					exp_pc, exp_wen, exp_reg, exp_data));
				if (exp_taken || redirect) begin
					score(1, redirect == exp_taken && (!exp_taken || redirect_pc == exp_target),
						$sformatf("pc %h redirect %b to %h, expected %b to %h",
						retire_pc, redirect, redirect_pc, exp_taken, exp_target));
				end
				r0_case = exp_wen && (exp_reg == '0 ||
					(w.r_view.opcode != cpu_types_pkg::LUI && w.r_view.rs == '0) ||
					(w.r_view.opcode == cpu_types_pkg::RTYPE && w.r_view.rt == '0));
				if (r0_case) begin
					score(4, retire_data == exp_data,
						$sformatf("pc %h with register 0 gave %h, expected %h",
						retire_pc, retire_data, exp_data));
				end
				retired++;
				if (retired == num_retire) begin
					for (int t = 0; t < 5; t++) begin
						$display("test %0d %s: %0d checks, %0d failed",
							t + 1, test_name(t), test_checks[t], test_errors[t]);
					end
					done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    instr_valid,
	input  cpu_types_pkg::instr_u   instr,
	input  cpu_types_pkg::word_t    instr_pc,
	output logic                    instr_ready,
	output logic                    retire_valid,
	output cpu_types_pkg::word_t    retire_pc,
	output logic                    retire_wen,
	output cpu_types_pkg::regbits_t retire_reg,
	output cpu_types_pkg::word_t    retire_data,
	input  logic                    retire_ready,
	output logic                    redirect,
	output cpu_types_pkg::word_t    redirect_pc
);

	logic stall;
	logic flush;
	logic rf_wen;
	cpu_types_pkg::regbits_t rf_waddr;
	cpu_types_pkg::word_t rf_wdata;

	////////////////////////////////////////
	// decode to ID/EX

	logic id_valid, id_alu_src, id_reg_dst, id_reg_wen, id_jump;
	cpu_types_pkg::word_t id_pc, id_rdat1, id_rdat2, id_immext;
	cpu_types_pkg::regbits_t id_rs, id_rt, id_rd;
	cpu_types_pkg::aluop_t id_alu_op;
	cpu_types_pkg::br_t id_br;
	logic [25:0] id_jaddr;

	// ID/EX to execute.
	logic idex_valid, idex_alu_src, idex_reg_dst, idex_reg_wen, idex_jump;
	cpu_types_pkg::word_t idex_pc, idex_rdat1, idex_rdat2, idex_immext;
	cpu_types_pkg::regbits_t idex_rs, idex_rt, idex_rd;
	cpu_types_pkg::aluop_t idex_alu_op;
	cpu_types_pkg::br_t idex_br;
	logic [25:0] idex_jaddr;

	// execute to retire.
	logic ex_valid, ex_wen, ex_redirect;
	cpu_types_pkg::word_t ex_pc, ex_data, ex_target;
	cpu_types_pkg::regbits_t ex_reg;

	decode_stage u_decode (.*);

	idex u_idex (.writeEN(!stall), .*);

	execute_stage u_execute (
		.fwd_wen(retire_wen), .fwd_reg(retire_reg), .fwd_data(retire_data), .*
	);

	retire_stage u_retire (.*);

endmodule

//--- cpu_types_pkg.sv
package cpu_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regbits_t;

	////////////////////////////////////////
	// instruction encodings

	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		LUI   = 6'h0f
	} opcode_t;

	typedef enum logic [5:0] {
		SLLV = 6'h04,
		SRLV = 6'h06,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_SLL,
		ALU_SRL,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI // passes operand b, which already holds the upper half.
	} aluop_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE
	} br_t;

	////////////////////////////////////////
	// the instruction word, seen as r, i or j format

	typedef struct packed {
		opcode_t  opcode;
		regbits_t rs;
		regbits_t rt;
		regbits_t rd;
		logic [4:0] shamt;
		funct_t   funct;
	} rtype_t;

	typedef struct packed {
		opcode_t  opcode;
		regbits_t rs;
		regbits_t rt;
		logic [15:0] imm16;
	} itype_t;

	typedef struct packed {
		opcode_t  opcode;
		logic [25:0] addr26;
	} jtype_t;

	typedef union packed {
		rtype_t r_view;
		itype_t i_view;
		jtype_t j_view;
	} instr_u;

endpackage

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    stall,
	input  logic                    flush,
	input  logic                    instr_valid,
	input  cpu_types_pkg::instr_u   instr,
	input  cpu_types_pkg::word_t    instr_pc,
	output logic                    instr_ready,
	input  logic                    rf_wen,
	input  cpu_types_pkg::regbits_t rf_waddr,
	input  cpu_types_pkg::word_t    rf_wdata,
	output logic                    id_valid,
	output cpu_types_pkg::word_t    id_pc,
	output cpu_types_pkg::word_t    id_rdat1,
	output cpu_types_pkg::word_t    id_rdat2,
	output cpu_types_pkg::word_t    id_immext,
	output cpu_types_pkg::regbits_t id_rs,
	output cpu_types_pkg::regbits_t id_rt,
	output cpu_types_pkg::regbits_t id_rd,
	output cpu_types_pkg::aluop_t   id_alu_op,
	output logic                    id_alu_src,
	output logic                    id_reg_dst,
	output logic                    id_reg_wen,
	output cpu_types_pkg::br_t      id_br,
	output logic                    id_jump,
	output logic [25:0]             id_jaddr
);

	logic ready_q; // comes up one cycle after reset.
	logic ifid_valid;
	cpu_types_pkg::word_t ifid_pc;
	cpu_types_pkg::instr_u ifid_instr;
	logic accept;
	logic zero_ext;
	logic illegal;
	logic [15:0] imm16;

	assign instr_ready = ready_q & !stall & !flush;
	assign accept = instr_valid & instr_ready;

	////////////////////////////////////////
	// IF/ID register

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ready_q <= 1'b0;
			ifid_valid <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			if (flush) begin
				ifid_valid <= 1'b0;
			end else if (!stall) begin
				ifid_valid <= accept; // a bubble when nothing was taken.
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			ifid_pc <= instr_pc;
			ifid_instr <= instr;
		end
	end

	register_file u_rf (
		.CLK(CLK), .nRST(nRST),
		.rsel1(ifid_instr.r_view.rs), .rsel2(ifid_instr.r_view.rt),
		.rdat1(id_rdat1), .rdat2(id_rdat2),
		.wen(rf_wen), .wsel(rf_waddr), .wdat(rf_wdata)
	);

	control_unit u_ctrl (
		.instr(ifid_instr), .alu_op(id_alu_op), .alu_src(id_alu_src),
		.reg_dst(id_reg_dst), .reg_wen(id_reg_wen), .jump(id_jump),
		.br(id_br), .zero_ext(zero_ext), .illegal(illegal)
	);

	assign imm16 = ifid_instr.i_view.imm16;
	assign id_valid = ifid_valid & !illegal; // unknown words drop out here.
	assign id_pc = ifid_pc;
	assign id_rs = ifid_instr.r_view.rs;
	assign id_rt = ifid_instr.r_view.rt;
	assign id_rd = ifid_instr.r_view.rd;
	assign id_jaddr = ifid_instr.j_view.addr26;

	always_comb begin
		if (id_alu_op == cpu_types_pkg::ALU_LUI) begin
			id_immext = {imm16, 16'h0000};
		end else if (zero_ext) begin
			id_immext = {16'h0000, imm16};
		end else begin
			id_immext = {{16{imm16[15]}}, imm16};
		end
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                    idex_valid,
	input  cpu_types_pkg::word_t    idex_pc,
	input  cpu_types_pkg::word_t    idex_rdat1,
	input  cpu_types_pkg::word_t    idex_rdat2,
	input  cpu_types_pkg::word_t    idex_immext,
	input  cpu_types_pkg::regbits_t idex_rs,
	input  cpu_types_pkg::regbits_t idex_rt,
	input  cpu_types_pkg::regbits_t idex_rd,
	input  cpu_types_pkg::aluop_t   idex_alu_op,
	input  logic                    idex_alu_src,
	input  logic                    idex_reg_dst,
	input  logic                    idex_reg_wen,
	input  cpu_types_pkg::br_t      idex_br,
	input  logic                    idex_jump,
	input  logic [25:0]             idex_jaddr,
	input  logic                    fwd_wen,
	input  cpu_types_pkg::regbits_t fwd_reg,
	input  cpu_types_pkg::word_t    fwd_data,
	output logic                    ex_valid,
	output cpu_types_pkg::word_t    ex_pc,
	output logic                    ex_wen,
	output cpu_types_pkg::regbits_t ex_reg,
	output cpu_types_pkg::word_t    ex_data,
	output logic                    ex_redirect,
	output cpu_types_pkg::word_t    ex_target
);

	cpu_types_pkg::word_t op_a;
	cpu_types_pkg::word_t op_b;
	cpu_types_pkg::word_t alu_b;
	cpu_types_pkg::word_t alu_out;
	cpu_types_pkg::word_t pc_plus4;
	cpu_types_pkg::word_t br_target;
	cpu_types_pkg::word_t j_target;
	logic equal;
	logic taken;

	////////////////////////////////////////
	// forwarding from the retire register

	always_comb begin
		op_a = idex_rdat1;
		op_b = idex_rdat2;
		if (fwd_wen && fwd_reg != '0 && fwd_reg == idex_rs) begin
			op_a = fwd_data;
		end
		if (fwd_wen && fwd_reg != '0 && fwd_reg == idex_rt) begin
			op_b = fwd_data;
		end
	end

	assign alu_b = idex_alu_src ? idex_immext : op_b;

	always_comb begin
		case (idex_alu_op)
			cpu_types_pkg::ALU_SLL: alu_out = alu_b << op_a[4:0]; // shift amount from rs.
			cpu_types_pkg::ALU_SRL: alu_out = alu_b >> op_a[4:0];
			cpu_types_pkg::ALU_ADD: alu_out = op_a + alu_b;
			cpu_types_pkg::ALU_SUB: alu_out = op_a - alu_b;
			cpu_types_pkg::ALU_AND: alu_out = op_a & alu_b;
			cpu_types_pkg::ALU_OR:  alu_out = op_a | alu_b;
			cpu_types_pkg::ALU_XOR: alu_out = op_a ^ alu_b;
			cpu_types_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
			cpu_types_pkg::ALU_LUI: alu_out = alu_b;
			default: alu_out = '0;
		endcase
	end

	////////////////////////////////////////
	// branch and jump resolution

	assign pc_plus4 = idex_pc + 32'd4;
	assign br_target = pc_plus4 + {idex_immext[29:0], 2'b00};
	assign j_target = {pc_plus4[31:28], idex_jaddr, 2'b00};
	assign equal = (op_a == op_b);

	always_comb begin
		case (idex_br)
			cpu_types_pkg::BR_EQ: taken = equal;
			cpu_types_pkg::BR_NE: taken = !equal;
			default: taken = idex_jump;
		endcase
	end

	assign ex_valid = idex_valid;
	assign ex_pc = idex_pc;
	assign ex_wen = idex_valid & idex_reg_wen;
	assign ex_reg = idex_reg_dst ? idex_rd : idex_rt;
	assign ex_data = alu_out;
	assign ex_redirect = idex_valid & taken;
	assign ex_target = idex_jump ? j_target : br_target;

endmodule

//--- idex.sv
`timescale 1ns/1ps

module idex (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    writeEN,
	input  logic                    flush,
	input  logic                    id_valid,
	input  cpu_types_pkg::word_t    id_pc,
	input  cpu_types_pkg::word_t    id_rdat1,
	input  cpu_types_pkg::word_t    id_rdat2,
	input  cpu_types_pkg::word_t    id_immext,
	input  cpu_types_pkg::regbits_t id_rs,
	input  cpu_types_pkg::regbits_t id_rt,
	input  cpu_types_pkg::regbits_t id_rd,
	input  cpu_types_pkg::aluop_t   id_alu_op,
	input  logic                    id_alu_src,
	input  logic                    id_reg_dst,
	input  logic                    id_reg_wen,
	input  cpu_types_pkg::br_t      id_br,
	input  logic                    id_jump,
	input  logic [25:0]             id_jaddr,
	output logic                    idex_valid,
	output cpu_types_pkg::word_t    idex_pc,
	output cpu_types_pkg::word_t    idex_rdat1,
	output cpu_types_pkg::word_t    idex_rdat2,
	output cpu_types_pkg::word_t    idex_immext,
	output cpu_types_pkg::regbits_t idex_rs,
	output cpu_types_pkg::regbits_t idex_rt,
	output cpu_types_pkg::regbits_t idex_rd,
	output cpu_types_pkg::aluop_t   idex_alu_op,
	output logic                    idex_alu_src,
	output logic                    idex_reg_dst,
	output logic                    idex_reg_wen,
	output cpu_types_pkg::br_t      idex_br,
	output logic                    idex_jump,
	output logic [25:0]             idex_jaddr
);

	// control fields, cleared into a bubble on reset or flush.
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			idex_valid <= 1'b0;
			idex_alu_op <= cpu_types_pkg::ALU_SLL;
			idex_alu_src <= 1'b0;
			idex_reg_dst <= 1'b0;
			idex_reg_wen <= 1'b0;
			idex_br <= cpu_types_pkg::BR_NONE;
			idex_jump <= 1'b0;
		end else if (flush) begin
			idex_valid <= 1'b0;
			idex_alu_op <= cpu_types_pkg::ALU_SLL;
			idex_alu_src <= 1'b0;
			idex_reg_dst <= 1'b0;
			idex_reg_wen <= 1'b0;
			idex_br <= cpu_types_pkg::BR_NONE;
			idex_jump <= 1'b0;
		end else if (writeEN) begin
			idex_valid <= id_valid;
			idex_alu_op <= id_alu_op;
			idex_alu_src <= id_alu_src;
			idex_reg_dst <= id_reg_dst;
			idex_reg_wen <= id_reg_wen;
			idex_br <= id_br;
			idex_jump <= id_jump;
		end
	end

	always_ff @(posedge CLK) begin
		if (writeEN) begin
			idex_pc <= id_pc;
			idex_rdat1 <= id_rdat1;
			idex_rdat2 <= id_rdat2;
			idex_immext <= id_immext;
			idex_rs <= id_rs;
			idex_rt <= id_rt;
			idex_rd <= id_rd;
			idex_jaddr <= id_jaddr;
		end
	end

	a_flush_bubble: assert property (@(posedge CLK) disable iff (!nRST)
		flush |=> !idex_valid);

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                    CLK,
	input  logic                    nRST,
	input  cpu_types_pkg::regbits_t rsel1,
	input  cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::word_t    rdat1,
	output cpu_types_pkg::word_t    rdat2,
	input  logic                    wen,
	input  cpu_types_pkg::regbits_t wsel,
	input  cpu_types_pkg::word_t    wdat
);

	cpu_types_pkg::word_t regs [32];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wsel != '0) begin // register 0 never takes a write.
			regs[wsel] <= wdat;
		end
	end

	// a write in the same cycle is seen by the reads.
	always_comb begin
		if (wen && wsel == rsel1 && rsel1 != '0) begin
			rdat1 = wdat;
		end else begin
			rdat1 = regs[rsel1];
		end
		if (wen && wsel == rsel2 && rsel2 != '0) begin
			rdat2 = wdat;
		end else begin
			rdat2 = regs[rsel2];
		end
	end

	a_reg0_zero: assert property (@(posedge CLK) disable iff (!nRST)
		(rsel1 == '0 |-> rdat1 == '0) and (rsel2 == '0 |-> rdat2 == '0));

endmodule

//--- retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic                    retire_ready,
	input  logic                    ex_valid,
	input  cpu_types_pkg::word_t    ex_pc,
	input  logic                    ex_wen,
	input  cpu_types_pkg::regbits_t ex_reg,
	input  cpu_types_pkg::word_t    ex_data,
	input  logic                    ex_redirect,
	input  cpu_types_pkg::word_t    ex_target,
	output logic                    retire_valid,
	output cpu_types_pkg::word_t    retire_pc,
	output logic                    retire_wen,
	output cpu_types_pkg::regbits_t retire_reg,
	output cpu_types_pkg::word_t    retire_data,
	output logic                    redirect,
	output cpu_types_pkg::word_t    redirect_pc,
	output logic                    stall,
	output logic                    flush,
	output logic                    rf_wen,
	output cpu_types_pkg::regbits_t rf_waddr,
	output cpu_types_pkg::word_t    rf_wdata
);

	assign stall = retire_valid & !retire_ready;
	assign flush = redirect & !stall; // squashes what follows a taken branch.

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			retire_valid <= 1'b0;
			retire_wen <= 1'b0;
			redirect <= 1'b0;
		end else if (!stall) begin
			retire_valid <= ex_valid & !flush;
			retire_wen <= ex_wen & !flush;
			redirect <= ex_valid & ex_redirect & !flush;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			retire_pc <= ex_pc;
			retire_reg <= ex_reg;
			retire_data <= ex_data;
			redirect_pc <= ex_target;
		end
	end

	assign rf_wen = retire_valid & retire_ready & retire_wen;
	assign rf_waddr = retire_reg;
	assign rf_wdata = retire_data;

	a_hold_stall: assert property (@(posedge CLK) disable iff (!nRST)
		stall |=> $stable({retire_valid, retire_pc, retire_wen, retire_reg,
			retire_data, redirect, redirect_pc}));

endmodule

//--- sources.f
cpu_types_pkg.sv
register_file.sv
control_unit.sv
decode_stage.sv
idex.sv
execute_stage.sv
retire_stage.sv
cpu_core.sv
cpu_checker.sv
tb_cpu_core.sv

//--- tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

	localparam int NUM_RETIRE = 2000;
	localparam int CYCLE_LIMIT = NUM_RETIRE * 12 + 200;

	logic CLK;
	logic nRST;
	logic instr_valid;
	cpu_types_pkg::instr_u instr;
	cpu_types_pkg::word_t instr_pc;
	logic instr_ready;
	logic retire_valid;
	cpu_types_pkg::word_t retire_pc;
	logic retire_wen;
	cpu_types_pkg::regbits_t retire_reg;
	cpu_types_pkg::word_t retire_data;
	logic retire_ready;
	logic redirect;
	cpu_types_pkg::word_t redirect_pc;

	cpu_types_pkg::word_t prog_mem [256];
	logic [31:0] lfsr;
	cpu_types_pkg::word_t fetch_pc; // pc of the word on offer.
	int warm;
	int cycles;
	logic chk_done;
	int chk_checks;
	int chk_errors;

	cpu_core u_dut (.*);

	cpu_checker u_chk (
		.CLK(CLK), .nRST(nRST), .num_retire(NUM_RETIRE),
		.instr_valid(instr_valid), .instr_ready(instr_ready),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_wen(retire_wen),
		.retire_reg(retire_reg), .retire_data(retire_data), .retire_ready(retire_ready),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.done(chk_done), .checks(chk_checks), .errors(chk_errors)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	////////////////////////////////////////
	// random source

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic cpu_types_pkg::funct_t pick_funct(input logic [2:0] k);
		case (k)
			3'd0: return cpu_types_pkg::SLLV;
			3'd1: return cpu_types_pkg::SRLV;
			3'd2: return cpu_types_pkg::ADDU;
			3'd3: return cpu_types_pkg::SUBU;
			3'd4: return cpu_types_pkg::AND;
			3'd5: return cpu_types_pkg::OR;
			3'd6: return cpu_types_pkg::XOR;
			default: return cpu_types_pkg::SLT;
		endcase
	endfunction

	// registers come from r0 to r7 so that hazards are frequent.
	function automatic cpu_types_pkg::instr_u make_instr(input int idx);
		cpu_types_pkg::instr_u w;
		logic [3:0] kind;
		int span;
		w = '0;
		kind = 4'(rand_bits(4));
		if (idx < 4 && kind >= 4'd12) begin
			kind = kind - 4'd4; // the opening words run straight through.
		end
		w.i_view.rs = cpu_types_pkg::regbits_t'(rand_bits(3));
		w.i_view.rt = cpu_types_pkg::regbits_t'(rand_bits(3));
		w.i_view.imm16 = 16'(rand_bits(16));
		span = int'(rand_bits(4));
		if (idx + 1 + span > 255) begin
			span = 255 - idx - 1;
		end
		case (kind)
			4'd8, 4'd15: w.i_view.opcode = cpu_types_pkg::ADDIU;
			4'd9:  w.i_view.opcode = cpu_types_pkg::ANDI;
			4'd10: w.i_view.opcode = cpu_types_pkg::ORI;
			4'd11: w.i_view.opcode = cpu_types_pkg::LUI;
			4'd12, 4'd13: begin
				w.i_view.opcode = (kind == 4'd12) ? cpu_types_pkg::BEQ : cpu_types_pkg::BNE;
				w.i_view.imm16 = 16'(span);
			end
			4'd14: begin
				w.j_view.opcode = cpu_types_pkg::J;
				w.j_view.addr26 = 26'(idx + 1 + span);
			end
			default: begin
				w.r_view.opcode = cpu_types_pkg::RTYPE;
				w.r_view.rd = cpu_types_pkg::regbits_t'(rand_bits(3));
				w.r_view.shamt = '0;
				w.r_view.funct = pick_funct(kind[2:0]);
			end
		endcase
		if (idx == 255) begin
			w = '0;
			w.j_view.opcode = cpu_types_pkg::J; // back to the start, forever.
		end
		return w;
	endfunction

	////////////////////////////////////////
	// program, reset and fetcher

	initial begin
		nRST = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		retire_ready = 1'b0;
		lfsr = 32'hdda1e6f8;
		fetch_pc = '0;
		warm = 0;
		for (int i = 0; i < 256; i++) begin
			prog_mem[i] = make_instr(i);
			u_chk.load_word(i, prog_mem[i]);
		end
		repeat (10) @(posedge CLK);
		#1;
		nRST = 1'b1;
		instr_valid = 1'b1;
		instr = prog_mem[0];
		retire_ready = 1'b1;
		forever begin
			@(posedge CLK);
			if (redirect && retire_valid && retire_ready) begin
				fetch_pc = redirect_pc;
			end else if (instr_valid && instr_ready) begin
				fetch_pc = fetch_pc + 32'd4;
			end
			#1;
			warm++;
			instr_valid = (warm < 8) ? 1'b1 : (rand_bits(2) != 0);
			retire_ready = (warm < 8) ? 1'b1 : (rand_bits(2) != 0);
			instr = prog_mem[fetch_pc[9:2]];
			instr_pc = fetch_pc;
		end
	end

	// end of run, either when the checker is done or at the cycle limit.
	initial begin
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
		end while (chk_done !== 1'b1 && cycles < CYCLE_LIMIT);
		if (chk_done !== 1'b1) begin
			$display("Timeout: the run stopped after %0d cycles without finishing.", cycles);
		end
		$display("totals: %0d checks, %0d failed", chk_checks, chk_errors);
		if (chk_done === 1'b1 && chk_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
